// File: bus_pkg.sv
package bus_pkg;

  localparam int xlen = 32;

  // address map
  localparam logic [31:0] sram_base = 32'h8000_0000;
  localparam int sram_words = 1024;
  localparam int sram_idx_bits = $clog2(sram_words);
  localparam logic [31:0] mtime_lo_addr = 32'h0200_bff8;
  localparam logic [31:0] mtime_hi_addr = 32'h0200_bffc;

  // axi size codes for single-beat transfers
  localparam logic [2:0] size_byte = 3'd0;
  localparam logic [2:0] size_half = 3'd1;
  localparam logic [2:0] size_word = 3'd2;

  localparam logic [1:0] resp_okay = 2'b00;

  // read arbiter states
  localparam logic [2:0] rd_fetch_addr = 3'd0;
  localparam logic [2:0] rd_fetch_data = 3'd1;
  localparam logic [2:0] rd_load_addr = 3'd2;
  localparam logic [2:0] rd_load_data = 3'd3;
  localparam logic [2:0] rd_load_flushed = 3'd4;

  // store states
  localparam logic [1:0] st_addr = 2'd0;
  localparam logic [1:0] st_write = 2'd1;
  localparam logic [1:0] st_resp = 2'd2;

  // one bus word as a whole or by byte lane
  typedef union packed {
    logic [xlen-1:0] word;
    logic [xlen/8-1:0][7:0] bytes;
  } bus_word_u;

endpackage

// File: core_bus.sv
`timescale 1ns/1ns
module core_bus (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     flush,
  // fetch
  input  logic [bus_pkg::xlen-1:0] ifu_araddr,
  input  logic                     ifu_arvalid,
  input  logic                     ifu_lock,
  output logic                     ifu_ready,
  output logic [bus_pkg::xlen-1:0] ifu_rdata,
  output logic                     ifu_rvalid,
  // load
  input  logic [bus_pkg::xlen-1:0] lsu_araddr,
  input  logic                     lsu_arvalid,
  input  logic [2:0]               lsu_size,
  output logic [bus_pkg::xlen-1:0] lsu_rdata,
  output logic                     lsu_rvalid,
  // store
  input  logic [bus_pkg::xlen-1:0] lsu_awaddr,
  input  logic                     lsu_awvalid,
  input  logic [bus_pkg::xlen-1:0] lsu_wdata,
  input  logic [3:0]               lsu_wstrb,
  output logic                     lsu_wready,
  // axi master
  output logic [bus_pkg::xlen-1:0] araddr,
  output logic [2:0]               arsize,
  output logic                     arvalid,
  input  logic                     arready,
  input  logic [bus_pkg::xlen-1:0] rdata,
  input  logic                     rvalid,
  output logic                     rready,
  output logic [bus_pkg::xlen-1:0] awaddr,
  output logic [2:0]               awsize,
  output logic                     awvalid,
  input  logic                     awready,
  output logic [bus_pkg::xlen-1:0] wdata,
  output logic [3:0]               wstrb,
  output logic                     wvalid,
  output logic                     wlast,
  input  logic                     wready,
  input  logic                     bvalid,
  output logic                     bready,
  // clint
  output logic [bus_pkg::xlen-1:0] clint_addr,
  output logic                     clint_rvalid_req,
  output logic                     clint_wen,
  output logic [bus_pkg::xlen-1:0] clint_wdata,
  output logic [3:0]               clint_wstrb,
  input  logic [bus_pkg::xlen-1:0] clint_rdata,
  input  logic                     clint_rvalid
);
  import bus_pkg::*;

  logic [2:0]      rd_state;
  logic [1:0]      st_state;
  logic [xlen-1:0] ld_addr;
  logic [2:0]      ld_size;
  logic            ld_hit;
  logic            ld_go;
  logic            ld_clint;
  logic            ld_flush_pend;  // flush seen before AR accepted
  logic            rd_done;
  logic            st_hit;
  logic            st_clint;
  logic            st_clint_go;
  logic            aw_done;
  logic            w_done;
  logic            aw_fire;
  logic            w_fire;
  bus_word_u       st_src;
  bus_word_u       st_lane;
  logic [3:0]      st_strb;

  function automatic logic is_mtime(input logic [xlen-1:0] addr);
    return (addr[xlen-1:2] == mtime_lo_addr[xlen-1:2]) ||
           (addr[xlen-1:2] == mtime_hi_addr[xlen-1:2]);
  endfunction

  assign ld_hit = is_mtime(lsu_araddr);
  assign ld_go = (rd_state == rd_fetch_addr) && !ifu_arvalid && lsu_arvalid &&
                 !ifu_lock && !flush;
  assign ld_clint = is_mtime(ld_addr);
  assign rd_done = ld_clint ? clint_rvalid : rvalid;

  always_ff @(posedge clock) begin
    if (reset) begin
      rd_state <= rd_fetch_addr;
      ld_flush_pend <= 1'b0;
    end else begin
      case (rd_state)
        rd_fetch_addr: begin
          if (ifu_arvalid) begin
            if (arready) rd_state <= rd_fetch_data;
          end else if (ld_go) begin
            rd_state <= ld_hit ? rd_load_data : rd_load_addr;  // mtime skips AR
            ld_flush_pend <= 1'b0;
          end
        end
        rd_fetch_data: begin
          if (rvalid) rd_state <= rd_fetch_addr;
        end
        rd_load_addr: begin
          if (arready) begin
            rd_state <= (flush || ld_flush_pend) ? rd_load_flushed : rd_load_data;
          end else if (flush) begin
            ld_flush_pend <= 1'b1;
          end
        end
        rd_load_data: begin
          if (rd_done) rd_state <= rd_fetch_addr;
          else if (flush) rd_state <= rd_load_flushed;
        end
        rd_load_flushed: begin
          if (rd_done) rd_state <= rd_fetch_addr;  // data dropped
        end
        default: rd_state <= rd_fetch_addr;
      endcase
    end
  end

  // load request held for the AR beat and the CLINT select
  always_ff @(posedge clock) begin
    if (ld_go) begin
      ld_addr <= lsu_araddr;
      ld_size <= lsu_size;
    end
  end

  always_comb begin
    if (rd_state == rd_fetch_addr) begin
      araddr = ifu_araddr;
      arsize = size_word;
      arvalid = ifu_arvalid;
    end else begin
      araddr = ld_addr;
      arsize = ld_size;
      arvalid = (rd_state == rd_load_addr);
    end
  end

  assign rready = 1'b1;
  assign ifu_ready = (rd_state == rd_fetch_addr);
  assign ifu_rvalid = (rd_state == rd_fetch_data) && rvalid;
  assign ifu_rdata = rdata;
  assign lsu_rvalid = (rd_state == rd_load_data) && rd_done && !flush;
  assign lsu_rdata = ld_clint ? clint_rdata : rdata;

  // store side
  assign st_hit = is_mtime(lsu_awaddr);
  assign st_clint_go = (st_state == st_addr) && lsu_awvalid && st_hit && !clint_rvalid_req;
  assign aw_fire = awvalid && awready;
  assign w_fire = wvalid && wready;

  always_ff @(posedge clock) begin
    if (reset) begin
      st_state <= st_addr;
      st_clint <= 1'b0;
      aw_done <= 1'b0;
      w_done <= 1'b0;
    end else begin
      case (st_state)
        st_addr: begin
          aw_done <= 1'b0;
          w_done <= 1'b0;
          if (st_clint_go) begin
            st_state <= st_resp;
            st_clint <= 1'b1;
          end else if (lsu_awvalid && !st_hit) begin
            st_state <= st_write;
            st_clint <= 1'b0;
          end
        end
        st_write: begin
          if (aw_fire) aw_done <= 1'b1;
          if (w_fire) w_done <= 1'b1;
          if ((aw_done || aw_fire) && (w_done || w_fire)) st_state <= st_resp;
        end
        st_resp: begin
          if (st_clint || bvalid) st_state <= st_addr;
        end
        default: st_state <= st_addr;
      endcase
    end
  end

  // shift store data up into the addressed lanes
  always_comb begin
    st_src.word = lsu_wdata;
    st_lane.word = '0;
    for (int i = 0; i < 4; i++) begin
      if (i >= int'(lsu_awaddr[1:0])) begin
        st_lane.bytes[i] = st_src.bytes[i - int'(lsu_awaddr[1:0])];
      end
    end
  end

  assign st_strb = lsu_wstrb << lsu_awaddr[1:0];

  always_comb begin
    case (lsu_wstrb)
      4'b0001: awsize = size_byte;
      4'b0011: awsize = size_half;
      default: awsize = size_word;
    endcase
  end

  assign awaddr = lsu_awaddr;
  assign awvalid = (st_state == st_write) && !aw_done;
  assign wdata = st_lane.word;
  assign wstrb = st_strb;
  assign wvalid = (st_state == st_write) && !w_done;
  assign wlast = wvalid;  // single beat
  assign bready = 1'b1;
  assign lsu_wready = (st_state == st_resp) && (st_clint || bvalid);

  // a clint load request wins the shared address
  assign clint_rvalid_req = ld_go && ld_hit;
  assign clint_wen = st_clint_go;
  assign clint_addr = clint_rvalid_req ? lsu_araddr : lsu_awaddr;
  assign clint_wdata = st_lane.word;
  assign clint_wstrb = st_strb;

endmodule

// File: bus_clint.sv
`timescale 1ns/1ns
module bus_clint (
  input  logic                     clock,
  input  logic                     reset,
  input  logic [bus_pkg::xlen-1:0] clint_addr,
  input  logic                     clint_rvalid_req,
  input  logic                     clint_wen,
  input  logic [bus_pkg::xlen-1:0] clint_wdata,
  input  logic [3:0]               clint_wstrb,
  output logic [bus_pkg::xlen-1:0] clint_rdata,
  output logic                     clint_rvalid
);
  import bus_pkg::*;

  logic [63:0]     mtime;
  logic [63:0]     mtime_wr;
  logic            sel_hi;
  logic [xlen-1:0] sel_word;

  // anything that is not the high word selects the low word
  assign sel_hi = (clint_addr[xlen-1:2] == mtime_hi_addr[xlen-1:2]);
  assign sel_word = sel_hi ? mtime[63:32] : mtime[31:0];

  // byte lane merge into the selected half
  always_comb begin
    mtime_wr = mtime;
    for (int i = 0; i < 4; i++) begin
      if (clint_wstrb[i]) begin
        if (sel_hi) begin
          mtime_wr[32 + 8*i +: 8] = clint_wdata[8*i +: 8];
        end else begin
          mtime_wr[8*i +: 8] = clint_wdata[8*i +: 8];
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      mtime <= 64'd0;
      clint_rvalid <= 1'b0;
    end else begin
      if (clint_wen) begin
        mtime <= mtime_wr;  // counting resumes next cycle
      end else begin
        mtime <= mtime + 64'd1;
      end
      clint_rvalid <= clint_rvalid_req;
    end
  end

  always_ff @(posedge clock) begin
    if (clint_rvalid_req) clint_rdata <= sel_word;
  end

endmodule

// File: axi_sram.sv
`timescale 1ns/1ns
module axi_sram (
  input  logic                     clock,
  input  logic                     reset,
  // read
  input  logic [bus_pkg::xlen-1:0] araddr,
  input  logic [2:0]               arsize,
  input  logic                     arvalid,
  output logic                     arready,
  output logic [bus_pkg::xlen-1:0] rdata,
  output logic [1:0]               rresp,
  output logic                     rvalid,
  input  logic                     rready,
  // write
  input  logic [bus_pkg::xlen-1:0] awaddr,
  input  logic [2:0]               awsize,
  input  logic                     awvalid,
  output logic                     awready,
  input  logic [bus_pkg::xlen-1:0] wdata,
  input  logic [3:0]               wstrb,
  input  logic                     wvalid,
  input  logic                     wlast,
  output logic                     wready,
  output logic                     bvalid,
  output logic [1:0]               bresp,
  input  logic                     bready
);
  import bus_pkg::*;

  logic [xlen-1:0] mem [sram_words];
  logic [1:0]      req_cnt;
  logic [2:0]      req_sum;
  logic            stall;
  logic            ar_fire;
  logic            aw_fire;
  logic            w_fire;
  logic            aw_full;
  logic            w_full;
  logic [xlen-1:0] aw_addr_q;
  logic [2:0]      aw_size_q;
  logic [xlen-1:0] w_data_q;
  logic [3:0]      w_strb_q;
  logic [xlen-1:0] wr_addr;
  logic [2:0]      wr_size;
  logic [3:0]      wr_strb;
  logic            wr_go;
  logic [3:0]      rd_lanes;
  bus_word_u       rd_word;
  bus_word_u       rd_masked;
  bus_word_u       wr_old;
  bus_word_u       wr_new;
  bus_word_u       wr_merged;

  // lanes touched by a narrow transfer
  function automatic logic [3:0] lane_mask(input logic [2:0] size, input logic [1:0] lo);
    case (size)
      size_byte: return 4'b0001 << lo;
      size_half: return 4'b0011 << {lo[1], 1'b0};
      default:   return 4'b1111;
    endcase
  endfunction

  function automatic logic [sram_idx_bits-1:0] word_idx(input logic [xlen-1:0] addr);
    logic [xlen-1:0] off;
    off = addr - sram_base;
    return off[sram_idx_bits+1:2];
  endfunction

  assign arready = !stall && !(rvalid && !rready);
  assign awready = !stall && !aw_full;
  assign wready = !w_full;
  assign ar_fire = arvalid && arready;
  assign aw_fire = awvalid && awready;
  assign w_fire = wvalid && wready && wlast;  // the only beat is the last
  assign req_sum = {1'b0, req_cnt} + 3'(ar_fire) + 3'(aw_fire);

  // every fourth request costs one address-ready cycle
  always_ff @(posedge clock) begin
    if (reset) begin
      req_cnt <= 2'd0;
      stall <= 1'b0;
    end else begin
      req_cnt <= req_sum[1:0];
      stall <= req_sum[2];
    end
  end

  always_comb begin
    rd_word.word = mem[word_idx(araddr)];
    for (int i = 0; i < 4; i++) begin
      rd_masked.bytes[i] = rd_lanes[i] ? rd_word.bytes[i] : 8'h00;
    end
  end

  assign rd_lanes = lane_mask(arsize, araddr[1:0]);

  always_ff @(posedge clock) begin
    if (reset) rvalid <= 1'b0;
    else if (ar_fire) rvalid <= 1'b1;
    else if (rready) rvalid <= 1'b0;
  end

  always_ff @(posedge clock) begin
    if (ar_fire) rdata <= rd_masked.word;
  end

  // AW and W may arrive in either order
  assign wr_addr = aw_full ? aw_addr_q : awaddr;
  assign wr_size = aw_full ? aw_size_q : awsize;
  assign wr_go = (aw_full || aw_fire) && (w_full || w_fire) && !(bvalid && !bready);

  always_comb begin
    wr_old.word = mem[word_idx(wr_addr)];
    wr_new.word = w_full ? w_data_q : wdata;
    wr_strb = (w_full ? w_strb_q : wstrb) & lane_mask(wr_size, wr_addr[1:0]);
    for (int i = 0; i < 4; i++) begin
      wr_merged.bytes[i] = wr_strb[i] ? wr_new.bytes[i] : wr_old.bytes[i];
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      aw_full <= 1'b0;
      w_full <= 1'b0;
      bvalid <= 1'b0;
    end else begin
      if (wr_go) begin
        aw_full <= 1'b0;
        w_full <= 1'b0;
        bvalid <= 1'b1;
      end else begin
        if (aw_fire) aw_full <= 1'b1;
        if (w_fire) w_full <= 1'b1;
        if (bready) bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (aw_fire) begin
      aw_addr_q <= awaddr;
      aw_size_q <= awsize;
    end
    if (w_fire) begin
      w_data_q <= wdata;
      w_strb_q <= wstrb;
    end
    if (wr_go) mem[word_idx(wr_addr)] <= wr_merged.word;
  end

  assign rresp = resp_okay;
  assign bresp = resp_okay;

endmodule

// File: bus_subsystem.sv
`timescale 1ns/1ns
module bus_subsystem (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     flush,
  input  logic [bus_pkg::xlen-1:0] ifu_araddr,
  input  logic                     ifu_arvalid,
  input  logic                     ifu_lock,
  output logic                     ifu_ready,
  output logic [bus_pkg::xlen-1:0] ifu_rdata,
  output logic                     ifu_rvalid,
  input  logic [bus_pkg::xlen-1:0] lsu_araddr,
  input  logic                     lsu_arvalid,
  input  logic [2:0]               lsu_size,
  output logic [bus_pkg::xlen-1:0] lsu_rdata,
  output logic                     lsu_rvalid,
  input  logic [bus_pkg::xlen-1:0] lsu_awaddr,
  input  logic                     lsu_awvalid,
  input  logic [bus_pkg::xlen-1:0] lsu_wdata,
  input  logic [3:0]               lsu_wstrb,
  output logic                     lsu_wready
);
  import bus_pkg::*;

  // axi between the bus unit and the sram
  logic [xlen-1:0] araddr;
  logic [2:0]      arsize;
  logic            arvalid;
  logic            arready;
  logic [xlen-1:0] rdata;
  logic            rvalid;
  logic            rready;
  logic [xlen-1:0] awaddr;
  logic [2:0]      awsize;
  logic            awvalid;
  logic            awready;
  logic [xlen-1:0] wdata;
  logic [3:0]      wstrb;
  logic            wvalid;
  logic            wlast;
  logic            wready;
  logic            bvalid;
  logic            bready;
  // timer port
  logic [xlen-1:0] clint_addr;
  logic            clint_rvalid_req;
  logic            clint_wen;
  logic [xlen-1:0] clint_wdata;
  logic [3:0]      clint_wstrb;
  logic [xlen-1:0] clint_rdata;
  logic            clint_rvalid;

  core_bus i_core_bus (
    .clock, .reset, .flush,
    .ifu_araddr, .ifu_arvalid, .ifu_lock, .ifu_ready, .ifu_rdata, .ifu_rvalid,
    .lsu_araddr, .lsu_arvalid, .lsu_size, .lsu_rdata, .lsu_rvalid,
    .lsu_awaddr, .lsu_awvalid, .lsu_wdata, .lsu_wstrb, .lsu_wready,
    .araddr, .arsize, .arvalid, .arready, .rdata, .rvalid, .rready,
    .awaddr, .awsize, .awvalid, .awready,
    .wdata, .wstrb, .wvalid, .wlast, .wready, .bvalid, .bready,
    .clint_addr, .clint_rvalid_req, .clint_wen, .clint_wdata, .clint_wstrb,
    .clint_rdata, .clint_rvalid
  );

  bus_clint i_bus_clint (
    .clock, .reset,
    .clint_addr, .clint_rvalid_req, .clint_wen, .clint_wdata, .clint_wstrb,
    .clint_rdata, .clint_rvalid
  );

  // responses are always OKAY and go unread
  axi_sram i_axi_sram (
    .clock, .reset,
    .araddr, .arsize, .arvalid, .arready, .rdata, .rresp(), .rvalid, .rready,
    .awaddr, .awsize, .awvalid, .awready,
    .wdata, .wstrb, .wvalid, .wlast, .wready,
    .bvalid, .bresp(), .bready
  );

endmodule

// File: bus_checker.sv
`timescale 1ns/1ns
module bus_checker (
  input logic       clock,
  input logic       reset,
  input logic       flush,
  input logic       arvalid,
  input logic       arready,
  input logic       awvalid,
  input logic       awready,
  input logic       wvalid,
  input logic       wready,
  input logic       bvalid,
  input logic       lsu_rvalid,
  input logic [2:0] rd_state,
  input logic [1:0] st_state
);
  import bus_pkg::*;

  int   fails = 0;
  logic flushed_ld;  // a flushed load still owns the read side

  always_ff @(posedge clock) begin
    if (reset) begin
      flushed_ld <= 1'b0;
    end else if (rd_state == rd_fetch_addr) begin
      flushed_ld <= 1'b0;
    end else if (flush && (rd_state == rd_load_addr || rd_state == rd_load_data)) begin
      flushed_ld <= 1'b1;
    end
  end

  // a raised valid stays up until its ready
  ar_hold: assert property (@(posedge clock) disable iff (reset)
    arvalid && !arready |=> arvalid)
    else begin
      $error("arvalid dropped before arready");
      fails++;
    end

  aw_hold: assert property (@(posedge clock) disable iff (reset)
    awvalid && !awready |=> awvalid)
    else begin
      $error("awvalid dropped before awready");
      fails++;
    end

  w_hold: assert property (@(posedge clock) disable iff (reset)
    wvalid && !wready |=> wvalid)
    else begin
      $error("wvalid dropped before wready");
      fails++;
    end

  // flushed load data never reaches the load stage
  no_flushed_data: assert property (@(posedge clock) disable iff (reset)
    !(lsu_rvalid && flushed_ld))
    else begin
      $error("lsu_rvalid raised for a flushed load");
      fails++;
    end

  b_pending: assert property (@(posedge clock) disable iff (reset)
    bvalid |-> st_state == st_resp)
    else begin
      $error("bvalid with no store waiting for it");
      fails++;
    end

endmodule

bind core_bus bus_checker i_bus_checker (
  .clock(clock),
  .reset(reset),
  .flush(flush),
  .arvalid(arvalid),
  .arready(arready),
  .awvalid(awvalid),
  .awready(awready),
  .wvalid(wvalid),
  .wready(wready),
  .bvalid(bvalid),
  .lsu_rvalid(lsu_rvalid),
  .rd_state(rd_state),
  .st_state(st_state)
);

// File: tb_bus_subsystem.sv
`timescale 1ns/1ns
module tb_bus_subsystem;
  import bus_pkg::*;

  localparam int timeout_cycles = 200;
  localparam int lock_hold_cycles = 12;

  logic            clock;
  logic            reset;
  logic            flush;
  logic [xlen-1:0] ifu_araddr;
  logic            ifu_arvalid;
  logic            ifu_lock;
  logic            ifu_ready;
  logic [xlen-1:0] ifu_rdata;
  logic            ifu_rvalid;
  logic [xlen-1:0] lsu_araddr;
  logic            lsu_arvalid;
  logic [2:0]      lsu_size;
  logic [xlen-1:0] lsu_rdata;
  logic            lsu_rvalid;
  logic [xlen-1:0] lsu_awaddr;
  logic            lsu_awvalid;
  logic [xlen-1:0] lsu_wdata;
  logic [3:0]      lsu_wstrb;
  logic            lsu_wready;

  int              test_num;
  int              fail_count;
  logic            timed_out;
  string           test_name;
  int              f_at;  // cycle of each completion pulse or -1
  int              l_at;
  int              s_at;
  logic [xlen-1:0] f_data;
  logic [xlen-1:0] l_data;

  bus_subsystem i_bus_subsystem (.*);

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  task automatic note_timeout(input string what);
    $display("test %s timed out after %0d cycles waiting for %s",
             test_name, timeout_cycles, what);
    timed_out = 1'b1;
    fail_count++;
  endtask

  task automatic report_word(input logic [xlen-1:0] exp, input logic [xlen-1:0] act);
    if (act !== exp) begin
      $display("** Error %s: expected %08h actual %08h", test_name, exp, act);
      fail_count++;
    end else begin
      $display("ok    %s", test_name);
    end
  endtask

  // sample at negedge and release each valid on the edge after its pulse
  task automatic await_done(input bit need_f, input bit need_l, input bit need_s);
    int cyc;
    cyc = 0;
    f_at = -1;
    l_at = -1;
    s_at = -1;
    while (!timed_out &&
           ((need_f && f_at < 0) || (need_l && l_at < 0) || (need_s && s_at < 0))) begin
      if (cyc == timeout_cycles) begin
        note_timeout("a completion pulse");
      end else begin
        @(negedge clock);
        cyc++;
        if (ifu_rvalid && f_at < 0) begin
          f_at = cyc;
          f_data = ifu_rdata;
        end
        if (lsu_rvalid && l_at < 0) begin
          l_at = cyc;
          l_data = lsu_rdata;
        end
        if (lsu_wready && s_at < 0) s_at = cyc;
        @(posedge clock);
        if (f_at >= 0) ifu_arvalid <= 1'b0;
        if (l_at >= 0) lsu_arvalid <= 1'b0;
        if (s_at >= 0) lsu_awvalid <= 1'b0;
      end
    end
  endtask

  task automatic issue_load(input logic [xlen-1:0] addr, input logic [2:0] size);
    @(posedge clock);
    lsu_araddr <= addr;
    lsu_size <= size;
    lsu_arvalid <= 1'b1;
  endtask

  task automatic issue_store(input logic [xlen-1:0] addr, input logic [xlen-1:0] data,
                             input logic [3:0] strb);
    lsu_awaddr <= addr;
    lsu_wdata <= data;
    lsu_wstrb <= strb;
    lsu_awvalid <= 1'b1;
  endtask

  task automatic load_and_check(input logic [xlen-1:0] addr, input logic [2:0] size,
                                input logic [xlen-1:0] exp);
    issue_load(addr, size);
    await_done(1'b0, 1'b1, 1'b0);
    if (addr == mtime_lo_addr) begin
      // counter runs on after the store
      if (l_data < exp || l_data >= exp + 32'd64) begin
        $display("** Error %s: expected %08h..%08h actual %08h",
                 test_name, exp, exp + 32'd63, l_data);
        fail_count++;
      end else begin
        $display("ok    %s", test_name);
      end
    end else begin
      report_word(exp, l_data);
    end
  endtask

  task automatic fetch_and_load(input logic [xlen-1:0] addr, input logic [2:0] size,
                                input logic [xlen-1:0] exp);
    @(posedge clock);
    ifu_araddr <= addr;
    ifu_arvalid <= 1'b1;
    lsu_araddr <= addr;
    lsu_size <= size;
    lsu_arvalid <= 1'b1;
    await_done(1'b1, 1'b1, 1'b0);
    if (l_at <= f_at) begin
      $display("%s: the load finished before the fetch", test_name);
      fail_count++;
    end else if (f_data !== exp) begin
      $display("** Error %s fetch: expected %08h actual %08h", test_name, exp, f_data);
      fail_count++;
    end else begin
      report_word(exp, l_data);
    end
  endtask

  task automatic locked_load(input logic [xlen-1:0] addr, input logic [2:0] size,
                             input logic [xlen-1:0] exp);
    logic early;
    early = 1'b0;
    @(posedge clock);
    ifu_lock <= 1'b1;
    lsu_araddr <= addr;
    lsu_size <= size;
    lsu_arvalid <= 1'b1;
    repeat (lock_hold_cycles) begin
      @(negedge clock);
      if (lsu_rvalid || !ifu_ready) early = 1'b1;
    end
    @(posedge clock);
    ifu_lock <= 1'b0;
    await_done(1'b0, 1'b1, 1'b0);
    if (early) begin
      $display("%s: the load started while ifu_lock was held", test_name);
      fail_count++;
    end else begin
      report_word(exp, l_data);
    end
  endtask

  task automatic flushed_load(input logic [xlen-1:0] addr, input logic [2:0] size,
                              input logic [xlen-1:0] exp);
    int   cyc;
    logic leaked;
    logic idle;
    leaked = 1'b0;
    idle = 1'b0;
    cyc = 0;
    issue_load(addr, size);
    @(negedge clock);
    while (ifu_ready && !timed_out) begin  // arbiter has not taken it yet
      if (cyc == timeout_cycles) begin
        note_timeout("the load to be accepted");
      end else begin
        @(negedge clock);
        cyc++;
      end
    end
    @(posedge clock);
    flush <= 1'b1;
    lsu_arvalid <= 1'b0;
    cyc = 0;
    while (!idle && !timed_out) begin
      if (cyc == timeout_cycles) begin
        note_timeout("the flushed load to drain");
      end else begin
        @(negedge clock);
        cyc++;
        if (lsu_rvalid) leaked = 1'b1;
        idle = ifu_ready;
        @(posedge clock);
        flush <= 1'b0;
      end
    end
    issue_load(addr, size);
    await_done(1'b0, 1'b1, 1'b0);
    if (leaked) begin
      $display("%s: the flushed load still raised lsu_rvalid", test_name);
      fail_count++;
    end else begin
      report_word(exp, l_data);
    end
  endtask

  task automatic run_line(input string kind, input logic [xlen-1:0] addr,
                          input logic [xlen-1:0] data, input logic [3:0] sel,
                          input logic [xlen-1:0] exp);
    test_num++;
    test_name = $sformatf("%0d %s %08h", test_num, kind, addr);
    if (kind == "store") begin
      @(posedge clock);
      issue_store(addr, data, sel);
      await_done(1'b0, 1'b0, 1'b1);
      $display("ok    %s", test_name);
    end else if (kind == "fetch") begin
      @(posedge clock);
      ifu_araddr <= addr;
      ifu_arvalid <= 1'b1;
      await_done(1'b1, 1'b0, 1'b0);
      report_word(exp, f_data);
    end else if (kind == "load") begin
      load_and_check(addr, sel[2:0], exp);
    end else if (kind == "fetchload") begin
      fetch_and_load(addr, sel[2:0], exp);
    end else if (kind == "lockload") begin
      locked_load(addr, sel[2:0], exp);
    end else if (kind == "loadflush") begin
      flushed_load(addr, sel[2:0], exp);
    end else if (kind == "storeload") begin
      @(posedge clock);
      issue_store(addr, data, sel);
      lsu_araddr <= addr + 32'd4;  // neighbour word read alongside the store
      lsu_size <= 3'd2;
      lsu_arvalid <= 1'b1;
      await_done(1'b0, 1'b1, 1'b1);
      report_word(exp, l_data);
    end else begin
      $display("test %s has an unknown operation in the trace", test_name);
      fail_count++;
    end
  endtask

  initial begin
    int               fd;
    int               code;
    string            kind;
    logic [8*128-1:0] rest;
    logic [xlen-1:0]  addr;
    logic [xlen-1:0]  data;
    logic [3:0]       sel;
    logic [xlen-1:0]  exp;
    reset <= 1'b1;
    flush <= 1'b0;
    ifu_araddr <= '0;
    ifu_arvalid <= 1'b0;
    ifu_lock <= 1'b0;
    lsu_araddr <= '0;
    lsu_arvalid <= 1'b0;
    lsu_size <= 3'd0;
    lsu_awaddr <= '0;
    lsu_awvalid <= 1'b0;
    lsu_wdata <= '0;
    lsu_wstrb <= 4'd0;
    test_num = 0;
    fail_count = 0;
    timed_out = 1'b0;
    test_name = "setup";
    repeat (2) @(posedge clock);
    reset <= 1'b0;

    fd = $fopen("bus_trace.txt", "r");
    if (fd == 0) begin
      $display("could not open bus_trace.txt");
      fail_count++;
    end else begin
      code = $fscanf(fd, "%s", kind);
      while (code == 1 && !timed_out) begin
        if (kind.getc(0) == 8'h23) begin
          code = $fgets(rest, fd);  // comment line
        end else begin
          code = $fscanf(fd, "%h %h %h %h", addr, data, sel, exp);
          if (code != 4) begin
            $display("trace line after test %0d is incomplete", test_num);
            fail_count++;
          end else begin
            run_line(kind, addr, data, sel, exp);
          end
        end
        code = $fscanf(fd, "%s", kind);
      end
      $fclose(fd);
    end

    fail_count += i_bus_subsystem.i_core_bus.i_bus_checker.fails;
    $display("tests %0d failed %0d", test_num, fail_count);
    if (fail_count == 0 && test_num > 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: files.f
bus_pkg.sv
core_bus.sv
bus_clint.sv
axi_sram.sv
bus_subsystem.sv
bus_checker.sv
tb_bus_subsystem.sv

// File: Makefile
TOP := tb_bus_subsystem

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the trace testbench"
	@echo "make clean  remove the Verilator build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f files.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir

// File: bus_trace.txt
# kind addr data strobe_or_size expected, all hex
# store data sits in the low lanes; storeload also reads addr+4
store 80000000 11223344 f 0
store 80000004 a5a5a5a5 f 0
store 80000008 cafef00d f 0
store 8000000c 01020304 f 0
store 80000010 deadbeef f 0
fetch 80000000 0 0 11223344
fetch 80000004 0 0 a5a5a5a5
# narrow stores at unaligned low bits
store 80000001 000000ab 1 0
store 80000003 0000009c 1 0
store 80000006 00005678 3 0
store 80000009 00778899 7 0
fetch 80000000 0 0 9c22ab44
load 80000004 0 2 5678a5a5
load 80000008 0 2 7788990d
load 80000001 0 0 0000ab00
load 80000006 0 1 56780000
# fetch priority and the fetch lock
fetchload 8000000c 0 2 01020304
fetchload 80000008 0 2 7788990d
lockload 80000010 0 2 deadbeef
# flush drops the first load, the retry returns data
loadflush 80000008 0 2 7788990d
loadflush 80000004 0 2 5678a5a5
# mtime, lo checked within a 64-cycle window
store 0200bffc 000000a5 f 0
store 0200bff8 00001000 f 0
load 0200bff8 0 2 00001000
load 0200bffc 0 2 000000a5
# store and load together under sram stalls
store 80000018 0badf00d f 0
store 8000001c 13579bdf f 0
store 80000020 2468ace0 f 0
storeload 80000014 00000001 f 0badf00d
storeload 80000018 00000002 f 13579bdf
storeload 8000001c 00000003 f 2468ace0
load 80000014 0 2 00000001
load 80000018 0 2 00000002
load 8000001c 0 2 00000003
fetch 80000018 0 0 00000002
